// ==== Makefile ====
# Verilator build and run for the ALU execute slice

VERILATOR ?= verilator
TOP       ?= alu_pipe_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv src/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line, not the exit code
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/alu_pipe_tb.sv ====
/*
 * Testbench for the ALU execute slice
 * Random op streams against a model register file, checked by assertions
 */

`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_pipe_tb;
  import alu_pkg::*;

  localparam int N_RESET = 3;
  localparam int N_ALU   = 48;   // 8 seeds plus 4 per micro-op
  localparam int N_RAW   = 40;
  localparam int N_STALL = 40;
  localparam int N_LAT   = 8;
  localparam int MAX_CYC = 4 * (N_RESET + N_ALU + N_RAW + N_STALL + N_LAT) * 10;

  typedef struct packed {
    seq_num_t   seq;
    word_t      pc;
    arch_addr_t waddr;
    preg_t      preg;
    preg_t      ppreg;
    word_t      data;
  } exp_t;

  logic       clk, rst;
  logic       issue_val, issue_rdy, issue_use_imm;
  word_t      issue_pc, issue_imm;
  seq_num_t   issue_seq_num;
  alu_uop_t   issue_uop;
  preg_t      issue_src1, issue_src2, issue_preg, issue_ppreg;
  arch_addr_t issue_waddr;
  logic       commit_val, commit_rdy;
  word_t      commit_pc, commit_data;
  seq_num_t   commit_seq_num;
  arch_addr_t commit_waddr;
  preg_t      commit_preg, commit_ppreg;

  // Model state
  word_t                     model_rf [`ALU_NUM_PREGS];
  exp_t                      exp_q [$];        // Issued, not yet committed
  exp_t                      head;             // Oldest outstanding op
  logic                      head_val = 1'b0;
  logic [`ALU_NUM_PREGS-1:0] tb_pend = '0;     // Dest in flight
  preg_t                     filled [$];       // Dests written so far
  preg_t                     last_dest = '0;
  int                        cyc = 0;
  int                        lat_cyc = 0;      // Edge count at latest issue
  int                        n_issued = 0;
  int                        errors = 0;
  int                        tests = 0;
  logic                      lat_mode = 1'b0;
  logic                      stall_mode = 1'b0;
  logic                      reset_chk = 1'b0;
  string                     test_name = "none";

  alu_pipe_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  function automatic word_t alu_ref(alu_uop_t op, word_t a, word_t b);
    logic [4:0] sh;
    word_t      fill;
    sh   = b[4:0];
    fill = ~(32'hffff_ffff >> sh);  // Ones in the top sh bits
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a + ~b + 32'd1;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << sh;
      OP_SRL:  return a >> sh;
      OP_SRA:  return (a >> sh) | (a[31] ? fill : 32'd0);
      // Differing signs decide by op1's sign alone
      OP_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      OP_SLTU: return {31'd0, a < b};
      default: return 32'd0;
    endcase
  endfunction

  always @(posedge clk) begin
    exp_t  e;
    word_t op1;
    word_t op2;
    if (rst) begin
      exp_q.delete();
      tb_pend <= '0;
      for (int i = 0; i < `ALU_NUM_PREGS; i++) begin
        model_rf[i] = '0;
      end
    end else begin
      if (issue_val && issue_rdy) begin
        op1     = model_rf[issue_src1];
        op2     = issue_use_imm ? issue_imm : model_rf[issue_src2];
        e.seq   = issue_seq_num;
        e.pc    = issue_pc;
        e.waddr = issue_waddr;
        e.preg  = issue_preg;
        e.ppreg = issue_ppreg;
        e.data  = alu_ref(issue_uop, op1, op2);
        exp_q.push_back(e);
        lat_cyc <= cyc;
        if (issue_preg != '0) tb_pend[issue_preg] <= 1'b1;
      end
      if (commit_val && commit_rdy && exp_q.size() > 0) begin
        e = exp_q.pop_front();
        if (e.preg != '0) begin   // Preg 0 stays zero
          model_rf[e.preg] = e.data;
          tb_pend[e.preg] <= 1'b0;
        end
      end
    end
    head_val <= exp_q.size() > 0;
    if (exp_q.size() > 0) head <= exp_q[0];
  end

  // Watchdog
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > MAX_CYC) begin
      $display("Timeout: run went past %0d cycles in test %s", MAX_CYC, test_name);
      $display("TB FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  task automatic report_mismatch(string what, word_t exp_v, word_t act_v);
    errors++;
    $display("ERROR %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
  endtask

  task automatic report_failure(string what);
    errors++;
    $display("Failure in %s: %s", test_name, what);
  endtask

  a_reset_state: assert property (@(posedge clk) reset_chk |-> !commit_val && issue_rdy)
    else report_failure("pipe not idle after reset");

  a_no_extra: assert property (@(posedge clk) disable iff (rst) commit_val |-> head_val)
    else report_failure("commit with no op outstanding");

  a_seq: assert property (@(posedge clk) disable iff (rst)
    commit_val && head_val |-> commit_seq_num == head.seq)
    else report_mismatch("seq_num", word_t'($sampled(head.seq)),
      word_t'($sampled(commit_seq_num)));

  a_pc: assert property (@(posedge clk) disable iff (rst)
    commit_val && head_val |-> commit_pc == head.pc)
    else report_mismatch("pc", $sampled(head.pc), $sampled(commit_pc));

  // Tags packed as waddr, preg, ppreg
  a_tags: assert property (@(posedge clk) disable iff (rst)
    commit_val && head_val |->
      {commit_waddr, commit_preg, commit_ppreg} == {head.waddr, head.preg, head.ppreg})
    else report_mismatch("waddr/preg/ppreg",
      word_t'($sampled({head.waddr, head.preg, head.ppreg})),
      word_t'($sampled({commit_waddr, commit_preg, commit_ppreg})));

  a_data: assert property (@(posedge clk) disable iff (rst)
    commit_val && head_val |-> commit_data == head.data)
    else report_mismatch("data", $sampled(head.data), $sampled(commit_data));

  a_raw_hold: assert property (@(posedge clk) disable iff (rst)
    issue_val && (tb_pend[issue_src1] || (!issue_use_imm && tb_pend[issue_src2]))
      |-> !issue_rdy)
    else report_failure("op accepted while a source was still in flight");

  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    commit_val && !commit_rdy |=> commit_val && $stable(commit_data)
      && $stable(commit_seq_num) && $stable(commit_pc) && $stable(commit_preg)
      && $stable(commit_waddr) && $stable(commit_ppreg))
    else report_failure("commit outputs moved while stalled");

  a_latency: assert property (@(posedge clk) disable iff (rst)
    lat_mode && commit_val |-> cyc == lat_cyc + 3)
    else report_mismatch("latency", word_t'($sampled(lat_cyc) + 3), word_t'($sampled(cyc)));

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  function automatic preg_t rand_preg();
    return preg_t'($urandom_range(`ALU_NUM_PREGS - 1, 0));
  endfunction

  function automatic preg_t pick_filled();
    if (filled.size() == 0) return '0;
    return filled[$urandom_range(filled.size() - 1, 0)];
  endfunction

  function automatic preg_t pick_dest();
    preg_t d;
    d = preg_t'($urandom_range(`ALU_NUM_PREGS - 1, 1));
    while (tb_pend[d]) begin
      d = preg_t'($urandom_range(`ALU_NUM_PREGS - 1, 1));
    end
    return d;
  endfunction

  // Called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic issue_op(alu_uop_t op, preg_t s1, preg_t s2, logic imm_en, word_t imm);
    preg_t dest;
    logic  taken;
    dest          = pick_dest();
    issue_val     = 1'b1;
    issue_uop     = op;
    issue_src1    = s1;
    issue_src2    = s2;
    issue_use_imm = imm_en;
    issue_imm     = imm;
    issue_seq_num = seq_num_t'(n_issued);
    issue_pc      = 32'h1000 + 32'(n_issued * 4);
    issue_waddr   = arch_addr_t'($urandom);
    issue_preg    = dest;
    issue_ppreg   = rand_preg();
    taken         = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = issue_rdy;              // Stable half a cycle before the edge
      @(posedge clk);
      #1;
    end
    issue_val = 1'b0;
    last_dest = dest;
    filled.push_back(dest);
    n_issued++;
  endtask

  task automatic run_stream(int n, int raw_pct);
    preg_t s1;
    preg_t s2;
    for (int i = 0; i < n; i++) begin
      s1 = ($urandom_range(99, 0) < raw_pct) ? last_dest : pick_filled();
      s2 = ($urandom_range(99, 0) < raw_pct) ? last_dest : rand_preg();
      issue_op(alu_uop_t'(4'($urandom_range(9, 0))), s1, s2,
        $urandom_range(1, 0) == 1, $urandom);
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic end_test(int err_start);
    tests++;
    $display("Test %-12s done, %0d errors", test_name, errors - err_start);
  endtask

  // Commit side stalls
  initial begin
    forever begin
      @(posedge clk);
      #1;
      commit_rdy = stall_mode ? ($urandom_range(2, 0) != 0) : 1'b1;
    end
  end

  initial begin
    int       err_start;
    alu_uop_t op;
    void'($urandom(32'hdc34));
    rst           = 1'b1;
    issue_val     = 1'b0;
    issue_pc      = '0;
    issue_seq_num = '0;
    issue_uop     = OP_ADD;
    issue_src1    = '0;
    issue_src2    = '0;
    issue_use_imm = 1'b0;
    issue_imm     = '0;
    issue_waddr   = '0;
    issue_preg    = '0;
    issue_ppreg   = '0;
    commit_rdy    = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst       = 1'b0;
    reset_chk = 1'b1;                 // Checked on the first edge out of reset

    test_name = "reset";
    err_start = errors;
    @(posedge clk);
    #1;
    reset_chk = 1'b0;
    issue_op(OP_ADD, '0, '0, 1'b0, '0);
    issue_op(OP_OR, rand_preg(), rand_preg(), 1'b0, '0);
    issue_op(OP_ADD, rand_preg(), '0, 1'b1, '0);
    drain();
    end_test(err_start);

    test_name = "alu_ops";
    err_start = errors;
    for (int i = 0; i < 8; i++) begin
      issue_op(OP_ADD, '0, '0, 1'b1, $urandom);  // Seed values, half negative
    end
    for (int k = 0; k < 10; k++) begin
      op = alu_uop_t'(4'(k));
      issue_op(op, pick_filled(), pick_filled(), 1'b0, '0);
      issue_op(op, pick_filled(), '0, 1'b1, $urandom);
      issue_op(op, pick_filled(), '0, 1'b1, 32'd0);
      // Max shift, or a negative immediate for the compares
      issue_op(op, pick_filled(), '0, 1'b1,
        (op inside {OP_SLL, OP_SRL, OP_SRA}) ? 32'd31 : 32'hffff_fff6);
    end
    drain();
    end_test(err_start);

    test_name = "order_raw";
    err_start = errors;
    run_stream(N_RAW, 60);
    drain();
    end_test(err_start);

    test_name  = "backpressure";
    err_start  = errors;
    stall_mode = 1'b1;
    run_stream(N_STALL, 30);
    drain();
    stall_mode = 1'b0;
    @(posedge clk);
    #1;
    end_test(err_start);

    test_name = "latency";
    err_start = errors;
    lat_mode  = 1'b1;
    for (int i = 0; i < N_LAT; i++) begin
      run_stream(1, 0);
      drain();                        // Empty pipe before the next op
    end
    lat_mode = 1'b0;
    end_test(err_start);

    $display("%0d tests run, %0d ops issued, %0d errors", tests, n_issued, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+src
src/alu_pkg.sv
src/alu_dispatch.sv
src/alu_execute.sv
src/alu_writeback.sv
src/alu_pipe_top.sv
dv/alu_pipe_tb.sv

// ==== src/alu_defines.svh ====
/*
 * ALU execute slice parameters
 * Word, sequence tag and physical register file sizes
 */

`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// --------------------------------------------------
// Datapath
// --------------------------------------------------

`define ALU_XLEN      32  // Data word width
`define ALU_SEQ_BITS  6   // Program order tag

// --------------------------------------------------
// Physical register file
// --------------------------------------------------

`define ALU_NUM_PREGS 64  // Entries, preg 0 hardwired to zero
`define ALU_PREG_BITS 6   // log2 of ALU_NUM_PREGS

`endif

// ==== src/alu_dispatch.sv ====
/*
 * ALU dispatch stage
 * Holds issue until both sources are ready, reads operands
 * from the register file and latches them into the issue register
 */

`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_dispatch (
  input  logic                 clk,
  input  logic                 rst,
  // Issue port
  input  logic                 issue_val,
  output logic                 issue_rdy,
  input  alu_pkg::word_t       issue_pc,
  input  alu_pkg::seq_num_t    issue_seq_num,
  input  alu_pkg::alu_uop_t    issue_uop,
  input  alu_pkg::preg_t       issue_src1,
  input  alu_pkg::preg_t       issue_src2,
  input  logic                 issue_use_imm,
  input  alu_pkg::word_t       issue_imm,
  input  alu_pkg::arch_addr_t  issue_waddr,
  input  alu_pkg::preg_t       issue_preg,
  input  alu_pkg::preg_t       issue_ppreg,
  // To execute
  output logic                 d_val,
  input  logic                 d_rdy,
  output alu_pkg::word_t       d_pc,
  output alu_pkg::seq_num_t    d_seq_num,
  output alu_pkg::alu_uop_t    d_uop,
  output alu_pkg::word_t       d_op1,
  output alu_pkg::word_t       d_op2,
  output alu_pkg::arch_addr_t  d_waddr,
  output alu_pkg::preg_t       d_preg,
  output alu_pkg::preg_t       d_ppreg,
  // Register file read and writeback strobe
  output alu_pkg::preg_t       rf_raddr1,
  output alu_pkg::preg_t       rf_raddr2,
  input  alu_pkg::word_t       rf_rdata1,
  input  alu_pkg::word_t       rf_rdata2,
  input  logic                 wb_val,
  input  alu_pkg::preg_t       wb_preg
);
  import alu_pkg::*;

  logic [`ALU_NUM_PREGS-1:0] pending;      // One bit per preg
  logic [`ALU_NUM_PREGS-1:0] pending_next;
  logic                      src1_busy;
  logic                      src2_busy;
  logic                      issue_xfer;
  logic                      d_xfer;
  word_t                     op2_sel;

  // --------------------------------------------------
  // Scoreboard
  // --------------------------------------------------

  assign src1_busy  = pending[issue_src1];
  assign src2_busy  = pending[issue_src2] & ~issue_use_imm; // Imm ops skip src2
  assign issue_rdy  = (d_rdy | ~d_val) & ~src1_busy & ~src2_busy;
  assign issue_xfer = issue_val & issue_rdy;
  assign d_xfer     = d_val & d_rdy;

  always_comb begin
    pending_next = pending;
    if (wb_val) begin
      pending_next[wb_preg] = 1'b0;   // Producer has written the file
    end
    // Preg 0 never becomes busy
    if (issue_xfer && issue_preg != '0) begin
      pending_next[issue_preg] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      pending <= pending_next;
    end
  end

  // --------------------------------------------------
  // Operand read and issue register
  // --------------------------------------------------

  assign rf_raddr1 = issue_src1;
  assign rf_raddr2 = issue_src2;
  assign op2_sel   = issue_use_imm ? issue_imm : rf_rdata2;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_val <= 1'b0;
    end else if (issue_xfer) begin
      d_val <= 1'b1;
    end else if (d_xfer) begin
      d_val <= 1'b0;                  // Drained, nothing new
    end
  end

  // Payload, no reset
  always_ff @(posedge clk) begin
    if (issue_xfer) begin
      d_pc      <= issue_pc;
      d_seq_num <= issue_seq_num;
      d_uop     <= issue_uop;
      d_op1     <= rf_rdata1;
      d_op2     <= op2_sel;
      d_waddr   <= issue_waddr;
      d_preg    <= issue_preg;
      d_ppreg   <= issue_ppreg;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // A second writer in flight would clear the bit early
  a_dest_free: assert property (@(posedge clk) disable iff (rst)
    issue_xfer && issue_preg != '0 |-> !pending[issue_preg])
    else $error("dispatch: destination p%0d already pending", issue_preg);

  a_wb_pending: assert property (@(posedge clk) disable iff (rst)
    wb_val |-> pending[wb_preg])
    else $error("dispatch: writeback to idle p%0d", wb_preg);

endmodule

// ==== src/alu_execute.sv ====
/*
 * ALU execute stage
 * One-entry register holding a dispatched op, with the
 * combinational ALU driving the writeback result
 */

`timescale 1ns/1ps

module alu_execute (
  input  logic                 clk,
  input  logic                 rst,
  // From dispatch
  input  logic                 d_val,
  output logic                 d_rdy,
  input  alu_pkg::word_t       d_pc,
  input  alu_pkg::seq_num_t    d_seq_num,
  input  alu_pkg::alu_uop_t    d_uop,
  input  alu_pkg::word_t       d_op1,
  input  alu_pkg::word_t       d_op2,
  input  alu_pkg::arch_addr_t  d_waddr,
  input  alu_pkg::preg_t       d_preg,
  input  alu_pkg::preg_t       d_ppreg,
  // To writeback
  output logic                 x_val,
  input  logic                 x_rdy,
  output alu_pkg::word_t       x_pc,
  output alu_pkg::seq_num_t    x_seq_num,
  output alu_pkg::arch_addr_t  x_waddr,
  output alu_pkg::preg_t       x_preg,
  output alu_pkg::preg_t       x_ppreg,
  output alu_pkg::word_t       x_wdata
);
  import alu_pkg::*;

  alu_uop_t   uop_q;
  word_t      op1_q;
  word_t      op2_q;
  logic       d_xfer;
  logic       x_xfer;
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // --------------------------------------------------
  // Stage register
  // --------------------------------------------------

  assign d_xfer = d_val & d_rdy;
  assign x_xfer = x_val & x_rdy;
  assign d_rdy  = x_rdy | ~x_val;     // Take a new op when empty or draining

  always_ff @(posedge clk) begin
    if (rst) begin
      x_val <= 1'b0;
    end else if (d_xfer) begin
      x_val <= 1'b1;
    end else if (x_xfer) begin
      x_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (d_xfer) begin
      x_pc      <= d_pc;
      x_seq_num <= d_seq_num;
      uop_q     <= d_uop;
      op1_q     <= d_op1;
      op2_q     <= d_op2;
      x_waddr   <= d_waddr;
      x_preg    <= d_preg;
      x_ppreg   <= d_ppreg;
    end
  end

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------

  assign shamt       = op2_q[4:0];    // RV32 shift amount
  assign lt_signed   = $signed(op1_q) < $signed(op2_q);
  assign lt_unsigned = op1_q < op2_q;

  always_comb begin
    case (uop_q)
      OP_ADD:  x_wdata = op1_q + op2_q;
      OP_SUB:  x_wdata = op1_q - op2_q;
      OP_AND:  x_wdata = op1_q & op2_q;
      OP_OR:   x_wdata = op1_q | op2_q;
      OP_XOR:  x_wdata = op1_q ^ op2_q;
      OP_SLL:  x_wdata = op1_q << shamt;
      OP_SRL:  x_wdata = op1_q >> shamt;
      OP_SRA:  x_wdata = word_t'($signed(op1_q) >>> shamt); // Sign fill
      OP_SLT:  x_wdata = word_t'(lt_signed);                // Zero extended
      OP_SLTU: x_wdata = word_t'(lt_unsigned);
      default: x_wdata = '0;
    endcase
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Covers encodings that arrive through dispatch unchecked
  a_uop_legal: assert property (@(posedge clk) disable iff (rst)
    x_val |-> !$isunknown(uop_q) && uop_q inside {OP_ADD, OP_SUB, OP_AND,
      OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU})
    else $error("execute: undefined micro-op %0d", uop_q);

endmodule

// ==== src/alu_pipe_top.sv ====
/*
 * ALU execute slice top
 * Dispatch, execute and writeback chained by valid/ready
 */

`timescale 1ns/1ps

module alu_pipe_top (
  input  logic                 clk,
  input  logic                 rst,
  // Issue port
  input  logic                 issue_val,
  output logic                 issue_rdy,
  input  alu_pkg::word_t       issue_pc,
  input  alu_pkg::seq_num_t    issue_seq_num,
  input  alu_pkg::alu_uop_t    issue_uop,
  input  alu_pkg::preg_t       issue_src1,
  input  alu_pkg::preg_t       issue_src2,
  input  logic                 issue_use_imm,
  input  alu_pkg::word_t       issue_imm,
  input  alu_pkg::arch_addr_t  issue_waddr,
  input  alu_pkg::preg_t       issue_preg,
  input  alu_pkg::preg_t       issue_ppreg,
  // Commit port
  output logic                 commit_val,
  input  logic                 commit_rdy,
  output alu_pkg::word_t       commit_pc,
  output alu_pkg::seq_num_t    commit_seq_num,
  output alu_pkg::arch_addr_t  commit_waddr,
  output alu_pkg::preg_t       commit_preg,
  output alu_pkg::preg_t       commit_ppreg,
  output alu_pkg::word_t       commit_data
);
  import alu_pkg::*;

  // Dispatch to execute
  logic       d_val, d_rdy;
  word_t      d_pc, d_op1, d_op2;
  seq_num_t   d_seq_num;
  alu_uop_t   d_uop;
  arch_addr_t d_waddr;
  preg_t      d_preg, d_ppreg;

  // Execute to writeback
  logic       x_val, x_rdy;
  word_t      x_pc, x_wdata;
  seq_num_t   x_seq_num;
  arch_addr_t x_waddr;
  preg_t      x_preg, x_ppreg;

  // Register file and scoreboard loop
  preg_t      rf_raddr1, rf_raddr2, wb_preg;
  word_t      rf_rdata1, rf_rdata2;
  logic       wb_val;

  alu_dispatch dispatch0 (
    .clk, .rst,
    .issue_val, .issue_rdy, .issue_pc, .issue_seq_num, .issue_uop,
    .issue_src1, .issue_src2, .issue_use_imm, .issue_imm,
    .issue_waddr, .issue_preg, .issue_ppreg,
    .d_val, .d_rdy, .d_pc, .d_seq_num, .d_uop, .d_op1, .d_op2,
    .d_waddr, .d_preg, .d_ppreg,
    .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
    .wb_val, .wb_preg
  );

  alu_execute execute0 (
    .clk, .rst,
    .d_val, .d_rdy, .d_pc, .d_seq_num, .d_uop, .d_op1, .d_op2,
    .d_waddr, .d_preg, .d_ppreg,
    .x_val, .x_rdy, .x_pc, .x_seq_num, .x_waddr, .x_preg, .x_ppreg,
    .x_wdata
  );

  alu_writeback writeback0 (
    .clk, .rst,
    .x_val, .x_rdy, .x_pc, .x_seq_num, .x_waddr, .x_preg, .x_ppreg,
    .x_wdata,
    .commit_val, .commit_rdy, .commit_pc, .commit_seq_num,
    .commit_waddr, .commit_preg, .commit_ppreg, .commit_data,
    .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
    .wb_val, .wb_preg
  );

endmodule

// ==== src/alu_pkg.sv ====
/*
 * ALU execute slice types
 * Vector typedefs for tagged widths and the micro-op encoding
 */

`include "alu_defines.svh"

package alu_pkg;

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------

  typedef logic [`ALU_XLEN-1:0]      word_t;      // Data word
  typedef logic [`ALU_SEQ_BITS-1:0]  seq_num_t;   // Program order tag
  typedef logic [4:0]                arch_addr_t; // Architectural dest
  typedef logic [`ALU_PREG_BITS-1:0] preg_t;      // Physical register

  // --------------------------------------------------
  // Micro-ops handled by the integer slice
  // --------------------------------------------------

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,  // Shifts use op2[4:0]
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,  // Arithmetic right
    OP_SLT  = 4'd8,  // Signed compare, result 1 or 0
    OP_SLTU = 4'd9   // Unsigned compare
  } alu_uop_t;

endpackage

// ==== src/alu_writeback.sv ====
/*
 * ALU writeback stage
 * Commit register, physical register file and its read ports
 */

`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_writeback (
  input  logic                 clk,
  input  logic                 rst,
  // From execute
  input  logic                 x_val,
  output logic                 x_rdy,
  input  alu_pkg::word_t       x_pc,
  input  alu_pkg::seq_num_t    x_seq_num,
  input  alu_pkg::arch_addr_t  x_waddr,
  input  alu_pkg::preg_t       x_preg,
  input  alu_pkg::preg_t       x_ppreg,
  input  alu_pkg::word_t       x_wdata,
  // Commit port
  output logic                 commit_val,
  input  logic                 commit_rdy,
  output alu_pkg::word_t       commit_pc,
  output alu_pkg::seq_num_t    commit_seq_num,
  output alu_pkg::arch_addr_t  commit_waddr,
  output alu_pkg::preg_t       commit_preg,
  output alu_pkg::preg_t       commit_ppreg,
  output alu_pkg::word_t       commit_data,
  // Register file read and scoreboard strobe
  input  alu_pkg::preg_t       rf_raddr1,
  input  alu_pkg::preg_t       rf_raddr2,
  output alu_pkg::word_t       rf_rdata1,
  output alu_pkg::word_t       rf_rdata2,
  output logic                 wb_val,
  output alu_pkg::preg_t       wb_preg
);
  import alu_pkg::*;

  word_t rf [`ALU_NUM_PREGS];         // Physical register file
  logic  x_xfer;
  logic  commit_xfer;

  // --------------------------------------------------
  // Commit register
  // --------------------------------------------------

  assign x_xfer      = x_val & x_rdy;
  assign commit_xfer = commit_val & commit_rdy;
  assign x_rdy       = commit_rdy | ~commit_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_val <= 1'b0;
    end else if (x_xfer) begin
      commit_val <= 1'b1;
    end else if (commit_xfer) begin
      commit_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (x_xfer) begin
      commit_pc      <= x_pc;
      commit_seq_num <= x_seq_num;
      commit_waddr   <= x_waddr;
      commit_preg    <= x_preg;
      commit_ppreg   <= x_ppreg;
      commit_data    <= x_wdata;
    end
  end

  // --------------------------------------------------
  // Register file
  // --------------------------------------------------

  // Written on the commit edge, preg 0 stays zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ALU_NUM_PREGS; i++) begin
        rf[i] <= '0;
      end
    end else if (commit_xfer && commit_preg != '0) begin
      rf[commit_preg] <= commit_data;
    end
  end

  assign rf_rdata1 = rf[rf_raddr1];   // Async reads for dispatch
  assign rf_rdata2 = rf[rf_raddr2];

  // Scoreboard clear, same edge as the file write
  assign wb_val  = commit_xfer & (commit_preg != '0);
  assign wb_preg = commit_preg;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  a_commit_hold: assert property (@(posedge clk) disable iff (rst)
    commit_val && !commit_rdy |=> commit_val
      && $stable(commit_pc) && $stable(commit_seq_num)
      && $stable(commit_waddr) && $stable(commit_preg)
      && $stable(commit_ppreg) && $stable(commit_data))
    else $error("writeback: commit outputs changed under stall");

endmodule
